// File: source/rs_pkg.sv
package rs_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and basic types
    ////////////////////////////////////////////////////////////////////////////

    localparam int tag_width  = 4;    // Reorder-buffer index
    localparam int data_width = 32;

    typedef logic [tag_width-1:0]  tag_t;
    typedef logic [data_width-1:0] data_t;

    // When ready is clear the operand waits for tag on the broadcast bus
    typedef struct packed {
        tag_t  tag;
        logic  ready;
        data_t value;
    } operand_t;    // 37 bits

    typedef struct packed {
        logic [31:0] instruction;    // Raw RISC-V encoding
        tag_t        dest_tag;
        operand_t    src1;
        operand_t    src2;
    } dispatch_packet_t;    // 110 bits

    typedef struct packed {
        logic [3:0]  alu_op;    // {funct7[5], funct3}
        logic        is_imm;
        logic [11:0] imm;
        tag_t        dest_tag;
    } alu_payload_t;    // 21 bits

    typedef struct packed {
        logic        is_store;
        logic [2:0]  size;    // funct3
        logic [11:0] imm;
        tag_t        dest_tag;
    } mem_payload_t;    // 20 bits

    typedef enum logic {
        unit_alu,
        unit_mem
    } unit_e;

    localparam logic [6:0] opcode_load   = 7'b0000011;
    localparam logic [6:0] opcode_store  = 7'b0100011;
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;

endpackage

// File: source/rs_if.sv
`timescale 1ns/1ps

// Dispatch to bank, entry written when valid and ready are both high
interface rs_alloc_if #(
    parameter type payload_t = logic
);
    logic              valid;
    logic              ready;    // Bank has a free entry
    payload_t          payload;
    rs_pkg::operand_t  src1;
    rs_pkg::operand_t  src2;

    modport dispatcher (output valid, output payload, output src1, output src2, input ready);
    modport bank       (input valid, input payload, input src1, input src2, output ready);
endinterface

// Bank to arbiter, entry freed when valid and grant are both high
interface rs_offer_if #(
    parameter type payload_t = logic
);
    logic           valid;    // A ready entry exists
    logic           grant;
    payload_t       payload;
    rs_pkg::data_t  value1;
    rs_pkg::data_t  value2;

    modport bank    (output valid, output payload, output value1, output value2, input grant);
    modport arbiter (input valid, input payload, input value1, input value2, output grant);
endinterface

// File: source/dispatch_decode.sv
`timescale 1ns/1ps

module dispatch_decode (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  rs_pkg::dispatch_packet_t wb_dat_i,
    output logic                     wb_ack,
    output logic                     wb_err,
    rs_alloc_if.dispatcher           int_alloc,
    rs_alloc_if.dispatcher           mem_alloc
);

    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic                 is_int;
    logic                 is_mem;
    logic                 request;
    rs_pkg::alu_payload_t alu_payload;
    rs_pkg::mem_payload_t mem_payload;

    assign opcode = wb_dat_i.instruction[6:0];
    assign funct3 = wb_dat_i.instruction[14:12];

    assign is_int = (opcode == rs_pkg::opcode_op) || (opcode == rs_pkg::opcode_op_imm);
    assign is_mem = (opcode == rs_pkg::opcode_load) || (opcode == rs_pkg::opcode_store);

    assign request = wb_cyc && wb_stb && !wb_ack && !wb_err;    // Strobe ignored while replying

    ////////////////////////////////////////////////////////////////////////////
    // Payload extraction
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        alu_payload.is_imm   = (opcode == rs_pkg::opcode_op_imm);
        alu_payload.dest_tag = wb_dat_i.dest_tag;
        // In OP-IMM bit 30 is an immediate bit except for the right shifts
        if (alu_payload.is_imm && funct3 != 3'b101) begin
            alu_payload.alu_op = {1'b0, funct3};
        end else begin
            alu_payload.alu_op = {wb_dat_i.instruction[30], funct3};
        end
        alu_payload.imm = alu_payload.is_imm ? wb_dat_i.instruction[31:20] : 12'd0;
    end

    always_comb begin
        mem_payload.is_store = (opcode == rs_pkg::opcode_store);
        mem_payload.size     = funct3;
        mem_payload.dest_tag = wb_dat_i.dest_tag;
        if (mem_payload.is_store) begin
            mem_payload.imm = {wb_dat_i.instruction[31:25], wb_dat_i.instruction[11:7]};    // S
        end else begin
            mem_payload.imm = wb_dat_i.instruction[31:20];    // I
        end
    end

    assign int_alloc.valid   = request && is_int;
    assign int_alloc.payload = alu_payload;
    assign int_alloc.src1    = wb_dat_i.src1;
    assign int_alloc.src2    = wb_dat_i.src2;

    assign mem_alloc.valid   = request && is_mem;
    assign mem_alloc.payload = mem_payload;
    assign mem_alloc.src1    = wb_dat_i.src1;
    assign mem_alloc.src2    = wb_dat_i.src2;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wb_ack <= 1'b0;
            wb_err <= 1'b0;
        end else begin
            wb_ack <= (int_alloc.valid && int_alloc.ready) || (mem_alloc.valid && mem_alloc.ready);
            wb_err <= request && !is_int && !is_mem;
        end
    end

    a_single_reply: assert property (@(posedge clock) disable iff (reset) !(wb_ack && wb_err));

endmodule

// File: source/rs_bank.sv
`timescale 1ns/1ps

module rs_bank #(
    parameter int  depth     = 4,
    parameter type payload_t = logic
) (
    input  logic          clock,
    input  logic          reset,
    rs_alloc_if.bank      alloc,
    rs_offer_if.bank      offer,
    input  logic          result_valid,
    input  rs_pkg::tag_t  result_tag,
    input  rs_pkg::data_t result_value
);

    localparam int idx_width = $clog2(depth);

    logic [depth-1:0]     busy;
    payload_t             payload_q [depth];
    rs_pkg::operand_t     op1_q [depth];
    rs_pkg::operand_t     op2_q [depth];

    logic [depth-1:0]     ready_vec;
    logic [idx_width-1:0] free_idx;
    logic [idx_width-1:0] lowest_ready;
    logic [idx_width-1:0] sel_idx;
    logic                 hold_q;    // Offer stalled last cycle
    logic [idx_width-1:0] hold_idx_q;
    logic                 write;
    logic                 fire;

    // Capture a broadcast into an operand that is still waiting for it
    function automatic rs_pkg::operand_t wake(input rs_pkg::operand_t op);
        rs_pkg::operand_t woken;
        woken = op;
        if (!op.ready && result_valid && op.tag == result_tag) begin
            woken.ready = 1'b1;
            woken.value = result_value;
        end
        return woken;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Entry selection
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < depth; i++) begin
            ready_vec[i] = busy[i] && op1_q[i].ready && op2_q[i].ready;
        end
    end

    always_comb begin
        free_idx     = '0;
        lowest_ready = '0;
        for (int i = depth - 1; i >= 0; i--) begin    // Downward so the lowest index wins
            if (!busy[i]) begin
                free_idx = idx_width'(i);
            end
            if (ready_vec[i]) begin
                lowest_ready = idx_width'(i);
            end
        end
    end

    // A stalled offer keeps its entry, so a lower one waking up cannot displace it
    assign sel_idx = hold_q ? hold_idx_q : lowest_ready;

    assign alloc.ready = !(&busy);
    assign write       = alloc.valid && alloc.ready;

    assign offer.valid   = |ready_vec;
    assign offer.payload = payload_q[sel_idx];
    assign offer.value1  = op1_q[sel_idx].value;
    assign offer.value2  = op2_q[sel_idx].value;
    assign fire          = offer.valid && offer.grant;

    ////////////////////////////////////////////////////////////////////////////
    // State
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy       <= '0;
            hold_q     <= 1'b0;
            hold_idx_q <= '0;
        end else begin
            if (write) begin
                busy[free_idx] <= 1'b1;
            end
            if (fire) begin
                busy[sel_idx] <= 1'b0;    // Never the slot being written
            end
            hold_q     <= offer.valid && !offer.grant;
            hold_idx_q <= sel_idx;
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < depth; i++) begin
            if (write && free_idx == idx_width'(i)) begin
                payload_q[i] <= alloc.payload;
                op1_q[i]     <= wake(alloc.src1);    // Bypass a same-edge broadcast
                op2_q[i]     <= wake(alloc.src2);
            end else begin
                op1_q[i] <= wake(op1_q[i]);
                op2_q[i] <= wake(op2_q[i]);
            end
        end
    end

    a_grant_needs_valid: assert property (
        @(posedge clock) disable iff (reset) offer.grant |-> offer.valid
    );

    // A write only ever lands in an entry that is free
    a_write_lands_free: assert property (
        @(posedge clock) disable iff (reset) write |-> !busy[free_idx]
    );

endmodule

// File: source/issue_arbiter.sv
`timescale 1ns/1ps

module issue_arbiter (
    input  logic          clock,
    input  logic          reset,
    rs_offer_if.arbiter   int_offer,
    rs_offer_if.arbiter   mem_offer,
    input  logic          issue_ready,
    output logic          issue_valid,
    output rs_pkg::unit_e issue_unit,
    output logic [3:0]    issue_op,
    output logic          issue_is_imm,
    output logic [11:0]   issue_imm,
    output rs_pkg::tag_t  issue_dest_tag,
    output rs_pkg::data_t issue_value1,
    output rs_pkg::data_t issue_value2
);

    rs_pkg::unit_e prio_q;
    rs_pkg::unit_e stall_unit_q;
    logic          stall_q;    // Offer not taken last cycle
    logic          contended;

    assign issue_valid = int_offer.valid || mem_offer.valid;
    assign contended   = int_offer.valid && mem_offer.valid;

    // A stalled choice is kept even if the other bank starts offering
    always_comb begin
        if (stall_q) begin
            issue_unit = stall_unit_q;
        end else if (contended) begin
            issue_unit = prio_q;
        end else if (mem_offer.valid) begin
            issue_unit = rs_pkg::unit_mem;
        end else begin
            issue_unit = rs_pkg::unit_alu;
        end
    end

    always_comb begin
        if (issue_unit == rs_pkg::unit_mem) begin
            issue_op       = {mem_offer.payload.is_store, mem_offer.payload.size};
            issue_is_imm   = 1'b1;
            issue_imm      = mem_offer.payload.imm;
            issue_dest_tag = mem_offer.payload.dest_tag;
            issue_value1   = mem_offer.value1;
            issue_value2   = mem_offer.value2;
        end else begin
            issue_op       = int_offer.payload.alu_op;
            issue_is_imm   = int_offer.payload.is_imm;
            issue_imm      = int_offer.payload.imm;
            issue_dest_tag = int_offer.payload.dest_tag;
            issue_value1   = int_offer.value1;
            issue_value2   = int_offer.value2;
        end
    end

    assign int_offer.grant = issue_ready && int_offer.valid && issue_unit == rs_pkg::unit_alu;
    assign mem_offer.grant = issue_ready && mem_offer.valid && issue_unit == rs_pkg::unit_mem;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            prio_q       <= rs_pkg::unit_alu;
            stall_q      <= 1'b0;
            stall_unit_q <= rs_pkg::unit_alu;
        end else begin
            if (issue_valid && issue_ready && contended) begin
                prio_q <= (issue_unit == rs_pkg::unit_alu) ? rs_pkg::unit_mem : rs_pkg::unit_alu;
            end
            stall_q      <= issue_valid && !issue_ready;
            stall_unit_q <= issue_unit;
        end
    end

    a_issue_stable: assert property (
        @(posedge clock) disable iff (reset)
        issue_valid && !issue_ready |=> issue_valid && $stable({issue_unit, issue_op,
            issue_is_imm, issue_imm, issue_dest_tag, issue_value1, issue_value2})
    );

endmodule

// File: source/rs_top.sv
`timescale 1ns/1ps

module rs_top #(
    parameter int int_depth = 4,
    parameter int mem_depth = 4
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  rs_pkg::dispatch_packet_t wb_dat_i,
    output logic                     wb_ack,
    output logic                     wb_err,
    input  logic                     result_valid,
    input  rs_pkg::tag_t             result_tag,
    input  rs_pkg::data_t            result_value,
    input  logic                     issue_ready,
    output logic                     issue_valid,
    output rs_pkg::unit_e            issue_unit,
    output logic [3:0]               issue_op,
    output logic                     issue_is_imm,
    output logic [11:0]              issue_imm,
    output rs_pkg::tag_t             issue_dest_tag,
    output rs_pkg::data_t            issue_value1,
    output rs_pkg::data_t            issue_value2
);

    rs_alloc_if #(.payload_t(rs_pkg::alu_payload_t)) int_alloc ();
    rs_alloc_if #(.payload_t(rs_pkg::mem_payload_t)) mem_alloc ();
    rs_offer_if #(.payload_t(rs_pkg::alu_payload_t)) int_offer ();
    rs_offer_if #(.payload_t(rs_pkg::mem_payload_t)) mem_offer ();

    dispatch_decode decode (
        .clock     (clock),
        .reset     (reset),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_dat_i  (wb_dat_i),
        .wb_ack    (wb_ack),
        .wb_err    (wb_err),
        .int_alloc (int_alloc.dispatcher),
        .mem_alloc (mem_alloc.dispatcher)
    );

    rs_bank #(
        .depth     (int_depth),
        .payload_t (rs_pkg::alu_payload_t)
    ) int_bank (
        .clock        (clock),
        .reset        (reset),
        .alloc        (int_alloc.bank),
        .offer        (int_offer.bank),
        .result_valid (result_valid),
        .result_tag   (result_tag),
        .result_value (result_value)
    );

    rs_bank #(
        .depth     (mem_depth),
        .payload_t (rs_pkg::mem_payload_t)
    ) mem_bank (
        .clock        (clock),
        .reset        (reset),
        .alloc        (mem_alloc.bank),
        .offer        (mem_offer.bank),
        .result_valid (result_valid),
        .result_tag   (result_tag),
        .result_value (result_value)
    );

    issue_arbiter arbiter (
        .clock          (clock),
        .reset          (reset),
        .int_offer      (int_offer.arbiter),
        .mem_offer      (mem_offer.arbiter),
        .issue_ready    (issue_ready),
        .issue_valid    (issue_valid),
        .issue_unit     (issue_unit),
        .issue_op       (issue_op),
        .issue_is_imm   (issue_is_imm),
        .issue_imm      (issue_imm),
        .issue_dest_tag (issue_dest_tag),
        .issue_value1   (issue_value1),
        .issue_value2   (issue_value2)
    );

endmodule

// File: tests/rs_checker.sv
`timescale 1ns/1ps

module rs_checker #(
    parameter int depth = 4
) (
    input logic                     clock,
    input logic                     reset,
    input logic                     wb_ack,
    input logic                     wb_err,
    input rs_pkg::dispatch_packet_t wb_dat_i,
    input logic                     result_valid,
    input rs_pkg::tag_t             result_tag,
    input rs_pkg::data_t            result_value,
    input logic                     issue_ready,
    input logic                     issue_valid,
    input rs_pkg::unit_e            issue_unit,
    input logic [3:0]               issue_op,
    input logic                     issue_is_imm,
    input logic [11:0]              issue_imm,
    input rs_pkg::tag_t             issue_dest_tag,
    input rs_pkg::data_t            issue_value1,
    input rs_pkg::data_t            issue_value2
);

    logic             m_valid [16];
    rs_pkg::unit_e    m_unit [16];
    logic [3:0]       m_op [16];
    logic             m_is_imm [16];
    logic [11:0]      m_imm [16];
    rs_pkg::operand_t m_src1 [16];
    rs_pkg::operand_t m_src2 [16];
    int               count [2];
    int               errors [6];
    int               full_seen;
    logic             prev_bc_valid;
    rs_pkg::tag_t     prev_bc_tag;
    rs_pkg::data_t    prev_bc_value;
    logic             prev_stall;
    logic [85:0]      prev_fields;
    logic             last_contended;
    rs_pkg::unit_e    last_unit;
    string            names [6] = '{"issue_fields", "illegal_opcode", "bank_full",
                                    "wakeup_order", "issue_hold", "alternation"};

    initial begin
        foreach (m_valid[i]) m_valid[i] = 1'b0;
        foreach (errors[i]) errors[i] = 0;
        count[0] = 0;
        count[1] = 0;
        full_seen = 0;
        prev_bc_valid = 1'b0;
        prev_stall = 1'b0;
        last_contended = 1'b0;
    end

    function automatic rs_pkg::operand_t wake(input rs_pkg::operand_t op, input logic v,
                                              input rs_pkg::tag_t t, input rs_pkg::data_t d);
        if (v && !op.ready && op.tag == t) begin
            op.ready = 1'b1;
            op.value = d;
        end
        return op;
    endfunction

    function automatic logic has_ready(input rs_pkg::unit_e u);
        logic found;
        found = 1'b0;
        for (int t = 0; t < 16; t++) begin
            if (m_valid[t] && m_unit[t] == u && m_src1[t].ready && m_src2[t].ready) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    task automatic compare(input int test, input string field, input logic [31:0] exp,
                           input logic [31:0] act);
        if (exp !== act) begin
            errors[test]++;
            $display("Mismatch %s (%s): expected %h, actual %h", names[test], field, exp, act);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Model updates, one pass per rising edge
    ////////////////////////////////////////////////////////////////////////////

    // Decoded fields follow the RISC-V base encodings
    task automatic commit(input rs_pkg::dispatch_packet_t p);
        logic [31:0]  ins;
        rs_pkg::tag_t t;
        ins = p.instruction;
        t = p.dest_tag;
        m_valid[t] = 1'b1;
        m_src1[t] = wake(p.src1, prev_bc_valid, prev_bc_tag, prev_bc_value);    // Write edge
        m_src2[t] = wake(p.src2, prev_bc_valid, prev_bc_tag, prev_bc_value);
        m_unit[t] = rs_pkg::unit_mem;
        m_is_imm[t] = 1'b1;
        m_imm[t] = ins[31:20];
        case (ins[6:0])
            rs_pkg::opcode_op: begin
                m_unit[t] = rs_pkg::unit_alu;
                m_op[t] = {ins[30], ins[14:12]};
                m_is_imm[t] = 1'b0;
                m_imm[t] = 12'd0;
            end
            rs_pkg::opcode_op_imm: begin
                m_unit[t] = rs_pkg::unit_alu;
                m_op[t] = {ins[14:12] == 3'b101 ? ins[30] : 1'b0, ins[14:12]};    // SRAI
            end
            rs_pkg::opcode_load: m_op[t] = {1'b0, ins[14:12]};
            rs_pkg::opcode_store: begin
                m_op[t] = {1'b1, ins[14:12]};
                m_imm[t] = {ins[31:25], ins[11:7]};
            end
            default: begin
                m_valid[t] = 1'b0;
                errors[1]++;
                $display("Illegal opcode %h with tag %0d was acked", ins[6:0], t);
            end
        endcase
        if (m_valid[t]) begin
            count[m_unit[t]]++;
            if (count[m_unit[t]] == depth) full_seen++;
            if (count[m_unit[t]] > depth) begin
                errors[2]++;
                $display("Bank for unit %0d holds more than %0d instructions", m_unit[t], depth);
            end
        end
    endtask

    task automatic check_issue(input logic contended);
        rs_pkg::tag_t t;
        t = issue_dest_tag;
        if (!m_valid[t]) begin
            errors[1]++;
            $display("Issue with tag %0d that has no acked instruction", t);
        end else begin
            compare(0, "unit", m_unit[t], issue_unit);
            compare(0, "op", m_op[t], issue_op);
            compare(0, "is_imm", m_is_imm[t], issue_is_imm);
            compare(0, "imm", m_imm[t], issue_imm);
            if (!m_src1[t].ready || !m_src2[t].ready) begin
                errors[3]++;
                $display("Tag %0d issued before its source tags were broadcast", t);
            end else begin
                compare(0, "value1", m_src1[t].value, issue_value1);
                compare(0, "value2", m_src2[t].value, issue_value2);
            end
            m_valid[t] = 1'b0;
            count[m_unit[t]]--;
        end
        if (contended && last_contended) compare(5, "issue_unit", !last_unit, issue_unit);
        last_contended = contended;
        last_unit = issue_unit;
    endtask

    // The ack edge follows the write edge, so an entry can already issue here
    always @(posedge clock) begin
        logic contended;
        logic [85:0] fields;
        if (!reset) begin
            fields = {issue_unit, issue_op, issue_is_imm, issue_imm, issue_dest_tag,
                      issue_value1, issue_value2};
            if (prev_stall) begin
                compare(4, "issue_valid", 1, issue_valid);
                compare(4, "fields", prev_fields[85:64], fields[85:64]);
                compare(4, "value1", prev_fields[63:32], fields[63:32]);
                compare(4, "value2", prev_fields[31:0], fields[31:0]);
            end
            if (wb_ack && wb_err) begin
                errors[1]++;
                $display("wb_ack and wb_err are high together");
            end else if (wb_ack) begin
                commit(wb_dat_i);
            end else if (wb_err && (wb_dat_i.instruction[6:0] inside {rs_pkg::opcode_op,
                     rs_pkg::opcode_op_imm, rs_pkg::opcode_load, rs_pkg::opcode_store})) begin
                errors[1]++;
                $display("wb_err for supported opcode %h", wb_dat_i.instruction[6:0]);
            end
            contended = has_ready(rs_pkg::unit_alu) && has_ready(rs_pkg::unit_mem);
            if (issue_valid && issue_ready) begin
                check_issue(contended);
            end else begin
                last_contended = 1'b0;
            end
            for (int t = 0; t < 16; t++) begin
                m_src1[t] = wake(m_src1[t], result_valid, result_tag, result_value);
                m_src2[t] = wake(m_src2[t], result_valid, result_tag, result_value);
            end
            prev_bc_valid = result_valid;
            prev_bc_tag   = result_tag;
            prev_bc_value = result_value;
            prev_stall    = issue_valid && !issue_ready;
            prev_fields   = fields;
        end
    end

    task automatic report(output int failed);
        failed = 0;
        for (int t = 0; t < 16; t++) begin
            if (m_valid[t]) begin
                errors[0]++;
                $display("Tag %0d was acked but never issued", t);
            end
        end
        if (full_seen == 0) begin
            errors[2]++;
            $display("No bank was ever filled to %0d instructions", depth);
        end
        foreach (errors[i]) begin
            $display("Test %s: %s (%0d errors)", names[i], errors[i] ? "FAIL" : "ok", errors[i]);
            if (errors[i] != 0) failed++;
        end
        $display("Tests run 6, passed %0d, failed %0d, full banks seen %0d",
                 6 - failed, failed, full_seen);
    endtask

endmodule

// File: tests/rs_tb.sv
`timescale 1ns/1ps

module rs_tb;

    localparam int depth = 4;

    logic                     clock;
    logic                     reset;
    logic                     wb_cyc;
    logic                     wb_stb;
    rs_pkg::dispatch_packet_t wb_dat_i;
    logic                     wb_ack;
    logic                     wb_err;
    logic                     result_valid;
    rs_pkg::tag_t             result_tag;
    rs_pkg::data_t            result_value;
    logic                     issue_ready;
    logic                     issue_valid;
    rs_pkg::unit_e            issue_unit;
    logic [3:0]               issue_op;
    logic                     issue_is_imm;
    logic [11:0]              issue_imm;
    rs_pkg::tag_t             issue_dest_tag;
    rs_pkg::data_t            issue_value1;
    rs_pkg::data_t            issue_value2;

    logic [15:0] in_flight;    // Acked, not yet issued
    logic [15:0] pending;      // Acked, not yet broadcast
    int          outstanding [2];

    rs_top #(.int_depth(depth), .mem_depth(depth)) DUT (.*);

    rs_checker #(.depth(depth)) check (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic abort(input string why);
        $display("Timeout: %s", why);
        $display("Simulation failed");
        $finish;
    endtask

    function automatic rs_pkg::tag_t pick_tag(input logic [15:0] mask);
        int start;
        rs_pkg::tag_t t;
        start = $urandom % 16;
        t = rs_pkg::tag_t'(start);
        for (int k = 15; k >= 0; k--) begin
            if (mask[(start + k) % 16]) t = rs_pkg::tag_t'((start + k) % 16);
        end
        return t;
    endfunction

    // A waiting source only when the target bank can take the packet at the next edge
    function automatic rs_pkg::operand_t make_operand(input logic may_wait);
        rs_pkg::operand_t op;
        op.value = $urandom;
        op.ready = 1'b1;
        op.tag   = rs_pkg::tag_t'($urandom);
        if (may_wait && pending != 0 && $urandom % 2 == 0) begin
            op.tag   = pick_tag(pending);
            op.ready = 1'b0;
        end
        return op;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Wishbone master
    ////////////////////////////////////////////////////////////////////////////

    task automatic dispatch_one();
        rs_pkg::dispatch_packet_t p;
        logic [6:0]               opc;
        rs_pkg::unit_e            unit;
        int                       cycles;
        cycles = 0;
        while ((in_flight | pending) == 16'hffff) begin
            @(negedge clock);
            cycles++;
            if (cycles > 500) abort("no free destination tag");
        end
        case ($urandom % 9)
            0, 1: opc = rs_pkg::opcode_op;
            2, 3: opc = rs_pkg::opcode_op_imm;
            4, 5: opc = rs_pkg::opcode_load;
            6, 7: opc = rs_pkg::opcode_store;
            default: opc = ($urandom % 2) ? 7'b1100011 : 7'b1010011;    // Branch, FP
        endcase
        unit = (opc == rs_pkg::opcode_load || opc == rs_pkg::opcode_store) ?
               rs_pkg::unit_mem : rs_pkg::unit_alu;
        p.instruction = {$urandom} & 32'hffff_ff80 | opc;
        p.dest_tag    = pick_tag(~(in_flight | pending));
        p.src1        = make_operand(outstanding[unit] < depth);
        p.src2        = make_operand(outstanding[unit] < depth);
        wb_dat_i = p;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        cycles   = 0;
        do begin
            @(negedge clock);
            cycles++;
            if (cycles > 500) abort("no wb_ack or wb_err for a dispatch");
        end while (!wb_ack && !wb_err);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        if (wb_ack) begin
            in_flight[p.dest_tag] = 1'b1;
            pending[p.dest_tag]   = 1'b1;
            outstanding[unit]++;
        end
        // The strobe is not sampled while the reply is high
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
            if (cycles > 500) abort("wb_ack or wb_err stays high");
        end while (wb_ack || wb_err);
    endtask

    always @(posedge clock) begin
        if (!reset && issue_valid && issue_ready) begin
            in_flight[issue_dest_tag] = 1'b0;
            outstanding[issue_unit]--;
        end
    end

    // Broadcasts for waiting tags and random back-pressure
    always @(negedge clock) begin
        rs_pkg::tag_t t;
        result_valid = 1'b0;
        if (!reset) begin
            issue_ready = ($urandom % 2) == 0;
            if (pending != 0 && $urandom % 3 == 0) begin
                t = pick_tag(pending);
                pending[t]   = 1'b0;
                result_tag   = t;
                result_value = $urandom;
                result_valid = 1'b1;
            end
        end
    end

    initial begin
        int failed;
        int cycles;
        void'($urandom(45));
        reset = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_dat_i = '0;
        result_valid = 1'b0;
        result_tag = '0;
        result_value = '0;
        issue_ready = 1'b0;
        in_flight = '0;
        pending = '0;
        outstanding[0] = 0;
        outstanding[1] = 0;
        repeat (8) @(negedge clock);
        reset = 1'b0;
        for (int n = 0; n < 300; n++) begin
            dispatch_one();
        end
        cycles = 0;
        while (in_flight != 0 || pending != 0) begin
            @(negedge clock);
            cycles++;
            if (cycles > 3000) abort("instructions left in the banks");
        end
        repeat (4) @(negedge clock);
        check.report(failed);
        if (failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
source/rs_pkg.sv
source/rs_if.sv
source/dispatch_decode.sv
source/rs_bank.sv
source/issue_arbiter.sv
source/rs_top.sv
tests/rs_checker.sv
tests/rs_tb.sv
